/* src/zelda_params.svh */
`ifndef ZELDA_PARAMS_SVH
`define ZELDA_PARAMS_SVH

// Playfield in tiles
`define MAP_W        20
`define MAP_H        15
`define TILE_PX      8   // Tile edge in pixels
`define MAP_WORDS    300 // MAP_W * MAP_H entries, row-major

// Spawn tile after every redraw
`define START_COL    1
`define START_ROW    1

// 3-bit palette, {R, G, B}
`define COL_FLOOR    3'b010 // Green
`define COL_WALL     3'b111 // White
`define COL_BUSH     3'b110 // Yellow
`define COL_PLAYER   3'b100 // Red

// Write-only redraw register, byte address
`define REDRAW_ADDR  12'h800

`endif

/* src/zelda_pkg.sv */
`default_nettype none

package zelda_pkg;

	// Map cell contents, 2 bits in RAM
	typedef enum logic [1:0] {
		FLOOR = 2'd0,
		WALL  = 2'd1,
		BUSH  = 2'd2   // Code 3 folded into WALL on host write
	} tile_t;

	typedef enum logic [1:0] {
		UP    = 2'd0,
		DOWN  = 2'd1,
		LEFT  = 2'd2,
		RIGHT = 2'd3
	} dir_t;

	// Work order from control to datapath
	typedef enum logic [2:0] {
		NONE   = 3'd0,
		INIT   = 3'd1,   // Full redraw
		MOVE   = 3'd2,
		ATTACK = 3'd3
	} action_t;

	typedef enum logic {CS_IDLE, CS_RUN} ctrl_state_t;

	typedef enum logic [2:0] {
		DS_IDLE, DS_LOOK, DS_DRAW_TILE, DS_DRAW_PLAYER, DS_SCAN
	} dp_state_t;

endpackage

`default_nettype wire

/* src/tile_port_if.sv */
`default_nettype none

// Game-side port of the tile RAM
interface tile_port_if;
	import zelda_pkg::*;

	logic [8:0] addr;    // row * MAP_W + col
	tile_t      rd_tile; // Valid one cycle after addr
	logic       we;
	tile_t      wr_tile;

	modport requester (
		output addr,
		output we,
		output wr_tile,
		input  rd_tile
	);

	modport memory (
		input  addr,
		input  we,
		input  wr_tile,
		output rd_tile
	);

endinterface

`default_nettype wire

/* src/map_store.sv */
`default_nettype none
`include "zelda_params.svh"

module map_store (
	input  logic        clock,
	input  logic        rst,
	// AXI4-Lite slave, host map port
	input  logic [11:0] s_awaddr,
	input  logic        s_awvalid,
	output logic        s_awready,
	input  logic [31:0] s_wdata,
	input  logic        s_wvalid,
	output logic        s_wready,
	output logic [1:0]  s_bresp,
	output logic        s_bvalid,
	input  logic        s_bready,
	input  logic [11:0] s_araddr,
	input  logic        s_arvalid,
	output logic        s_arready,
	output logic [31:0] s_rdata,
	output logic [1:0]  s_rresp,
	output logic        s_rvalid,
	input  logic        s_rready,
	tile_port_if.memory tile,
	output logic        redraw_req
);
	import zelda_pkg::*;

	tile_t       ram [`MAP_WORDS];
	tile_t       host_q;             // Host read data
	tile_t       game_q;
	tile_t       wtile;
	logic        wr_acc;             // Drives awready and wready together
	logic        wr_fire, rd_fire;
	logic        aw_map, aw_redraw, ar_map;

	// Word index from byte address, must be aligned
	assign aw_map    = (s_awaddr[1:0] == 2'b00) && (s_awaddr[11:2] < 10'(`MAP_WORDS));
	assign aw_redraw = (s_awaddr == `REDRAW_ADDR);
	assign ar_map    = (s_araddr[1:0] == 2'b00) && (s_araddr[11:2] < 10'(`MAP_WORDS));

	assign s_awready = wr_acc;
	assign s_wready  = wr_acc;
	assign wr_fire   = wr_acc && s_awvalid && s_wvalid;
	// Host port is shared, so reads wait out a write beat
	assign s_arready = !s_rvalid && !wr_acc;
	assign rd_fire   = s_arvalid && s_arready;

	assign wtile = (s_wdata[1:0] == 2'd3) ? WALL : tile_t'(s_wdata[1:0]); // Code 3 as WALL

	assign s_rdata      = {30'd0, host_q};
	assign tile.rd_tile = game_q;

	// Tile RAM, host port then game port
	always_ff @(posedge clock) begin
		if (wr_fire && aw_map)
			ram[s_awaddr[10:2]] <= wtile;
		if (rd_fire)
			host_q <= ar_map ? ram[s_araddr[10:2]] : FLOOR;
		if (tile.we && (tile.addr < 9'(`MAP_WORDS)))
			ram[tile.addr] <= tile.wr_tile; // Same address, game write lands last
		game_q <= (tile.addr < 9'(`MAP_WORDS)) ? ram[tile.addr] : WALL; // Off map is solid
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			wr_acc     <= 1'b0;
			s_bvalid   <= 1'b0;
			s_rvalid   <= 1'b0;
			redraw_req <= 1'b0;
		end else begin
			wr_acc     <= !wr_acc && !s_bvalid && s_awvalid && s_wvalid; // One-cycle accept
			redraw_req <= wr_fire && aw_redraw;
			if (wr_fire)
				s_bvalid <= 1'b1;
			else if (s_bready)
				s_bvalid <= 1'b0;
			if (rd_fire)
				s_rvalid <= 1'b1;
			else if (s_rready)
				s_rvalid <= 1'b0;
		end
	end

	// Response codes, OKAY or SLVERR
	always_ff @(posedge clock) begin
		if (wr_fire)
			s_bresp <= (aw_map || aw_redraw) ? 2'b00 : 2'b10;
		if (rd_fire)
			s_rresp <= ar_map ? 2'b00 : 2'b10;
	end

endmodule

`default_nettype wire

/* src/control.sv */
`default_nettype none

module control (
	input  logic               clock,
	input  logic               rst,
	input  logic               btn_up,
	input  logic               btn_down,
	input  logic               btn_left,
	input  logic               btn_right,
	input  logic               btn_attack,
	input  logic               redraw_req,
	output zelda_pkg::action_t action,
	output zelda_pkg::dir_t    dir,
	output logic               start,
	input  logic               done,
	output logic               ready
);
	import zelda_pkg::*;

	ctrl_state_t state;
	logic [4:0]  btn_now, btn_q, btn_edge;
	logic        redraw_pend;  // Redraw that came in while busy
	dir_t        facing;
	logic        issue;
	action_t     next_act;
	dir_t        next_dir;

	assign btn_now  = {btn_up, btn_down, btn_left, btn_right, btn_attack};
	assign btn_edge = btn_now & ~btn_q;   // Rising edges only
	assign ready    = (state == CS_IDLE);
	assign dir      = facing;             // Move and attack both use facing

	// Pick one action, redraw first, attack last
	always_comb begin
		issue    = 1'b1;
		next_act = NONE;
		next_dir = facing;
		if (redraw_pend || redraw_req) begin
			next_act = INIT;
		end else if (btn_edge[4]) begin
			next_act = MOVE;
			next_dir = UP;
		end else if (btn_edge[3]) begin
			next_act = MOVE;
			next_dir = DOWN;
		end else if (btn_edge[2]) begin
			next_act = MOVE;
			next_dir = LEFT;
		end else if (btn_edge[1]) begin
			next_act = MOVE;
			next_dir = RIGHT;
		end else if (btn_edge[0]) begin
			next_act = ATTACK;
		end else begin
			issue = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state       <= CS_IDLE;
			btn_q       <= '0;
			redraw_pend <= 1'b0;
			facing      <= DOWN;
			action      <= NONE;
			start       <= 1'b0;
		end else begin
			btn_q <= btn_now;   // Edges while busy are lost here
			start <= 1'b0;
			if (redraw_req)
				redraw_pend <= 1'b1;
			case (state)
				CS_IDLE: if (issue) begin
					action <= next_act;
					facing <= next_dir;   // Turn even if the move is blocked
					start  <= 1'b1;
					state  <= CS_RUN;
					if (next_act == INIT)
						redraw_pend <= 1'b0;
				end
				CS_RUN: if (done)
					state <= CS_IDLE;
				default: state <= CS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/datapath.sv */
`default_nettype none
`include "zelda_params.svh"

module datapath (
	input  logic               clock,
	input  logic               rst,
	input  zelda_pkg::action_t action,
	input  zelda_pkg::dir_t    dir,
	input  logic               start,
	output logic               done,
	tile_port_if.requester     tile,
	output logic [7:0]         x,
	output logic [6:0]         y,
	output logic [2:0]         colour,
	output logic               plot
);
	import zelda_pkg::*;

	dp_state_t  state;
	action_t    act;           // Action latched at start
	logic [4:0] pcol;          // Player tile
	logic [3:0] prow;
	logic [4:0] tcol;          // Neighbour in dir
	logic [3:0] trow;
	logic       tgt_ok;
	logic [4:0] scol;          // Redraw scan position
	logic [3:0] srow;
	logic [4:0] dcol;          // Tile being plotted
	logic [3:0] drow;
	logic [2:0] dclr;
	logic [5:0] pix;           // {row, col} inside the tile
	logic       last_pix, last_scan;

	function automatic logic [8:0] tile_addr(input logic [4:0] col, input logic [3:0] row);
		return 9'(row * `MAP_W + col);
	endfunction

	function automatic logic [2:0] colour_of(input tile_t t);
		case (t)
			FLOOR:   return `COL_FLOOR;
			BUSH:    return `COL_BUSH;
			default: return `COL_WALL;
		endcase
	endfunction

	// Neighbour tile and grid bounds
	always_comb begin
		tcol   = pcol;
		trow   = prow;
		tgt_ok = 1'b1;
		case (dir)
			UP: begin
				trow   = prow - 4'd1;
				tgt_ok = (prow != 4'd0);
			end
			DOWN: begin
				trow   = prow + 4'd1;
				tgt_ok = (prow != 4'(`MAP_H - 1));
			end
			LEFT: begin
				tcol   = pcol - 5'd1;
				tgt_ok = (pcol != 5'd0);
			end
			default: begin
				tcol   = pcol + 5'd1;
				tgt_ok = (pcol != 5'(`MAP_W - 1));
			end
		endcase
	end

	// Scan address only during SCAN, else the neighbour
	assign tile.addr    = (state == DS_SCAN) ? tile_addr(scol, srow) : tile_addr(tcol, trow);
	assign tile.we      = (state == DS_LOOK) && (act == ATTACK) && (tile.rd_tile == BUSH);
	assign tile.wr_tile = FLOOR;   // Only writes are bush clears

	assign last_pix  = (pix == 6'(`TILE_PX * `TILE_PX - 1));
	assign last_scan = (scol == 5'(`MAP_W - 1)) && (srow == 4'(`MAP_H - 1));

	// Pixel plotter
	assign plot   = (state == DS_DRAW_TILE) || (state == DS_DRAW_PLAYER);
	assign x      = 8'(dcol) * 8'(`TILE_PX) + 8'(pix[2:0]);
	assign y      = 7'(drow) * 7'(`TILE_PX) + 7'(pix[5:3]);
	assign colour = dclr;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= DS_IDLE;
			act   <= NONE;
			done  <= 1'b0;
			pcol  <= 5'(`START_COL);
			prow  <= 4'(`START_ROW);
		end else begin
			done <= 1'b0;
			case (state)
				DS_IDLE: if (start) begin
					act <= action;
					case (action)
						INIT: begin
							pcol  <= 5'(`START_COL);
							prow  <= 4'(`START_ROW);
							scol  <= '0;
							srow  <= '0;
							state <= DS_SCAN;
						end
						MOVE, ATTACK:
							if (tgt_ok)
								state <= DS_LOOK;  // Read issued this cycle
							else
								done <= 1'b1;      // Off grid, nothing to do
						default: done <= 1'b1;
					endcase
				end
				DS_SCAN: state <= DS_LOOK;   // Scan address out
				DS_LOOK: begin
					pix <= '0;
					case (act)
						INIT: begin
							dcol  <= scol;
							drow  <= srow;
							dclr  <= colour_of(tile.rd_tile);
							state <= DS_DRAW_TILE;
						end
						MOVE: if (tile.rd_tile == FLOOR) begin
							dcol  <= pcol;         // Old tile back to floor
							drow  <= prow;
							dclr  <= `COL_FLOOR;
							pcol  <= tcol;
							prow  <= trow;
							state <= DS_DRAW_TILE;
						end else begin
							done  <= 1'b1;         // Blocked
							state <= DS_IDLE;
						end
						ATTACK: if (tile.rd_tile == BUSH) begin
							dcol  <= tcol;         // RAM write happens this cycle
							drow  <= trow;
							dclr  <= `COL_FLOOR;
							state <= DS_DRAW_TILE;
						end else begin
							done  <= 1'b1;
							state <= DS_IDLE;
						end
						default: begin
							done  <= 1'b1;
							state <= DS_IDLE;
						end
					endcase
				end
				DS_DRAW_TILE: begin
					pix <= pix + 6'd1;   // Wraps to 0 after the last pixel
					if (last_pix) begin
						case (act)
							INIT: if (last_scan) begin
								dcol  <= pcol;
								drow  <= prow;
								dclr  <= `COL_PLAYER;
								state <= DS_DRAW_PLAYER;
							end else begin
								if (scol == 5'(`MAP_W - 1)) begin
									scol <= '0;
									srow <= srow + 4'd1;
								end else begin
									scol <= scol + 5'd1;
								end
								state <= DS_SCAN;
							end
							MOVE: begin
								dcol  <= pcol;   // Already the new tile
								drow  <= prow;
								dclr  <= `COL_PLAYER;
								state <= DS_DRAW_PLAYER;
							end
							default: begin
								done  <= 1'b1;
								state <= DS_IDLE;
							end
						endcase
					end
				end
				DS_DRAW_PLAYER: begin
					pix <= pix + 6'd1;
					if (last_pix) begin
						done  <= 1'b1;
						state <= DS_IDLE;
					end
				end
				default: state <= DS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/zelda.sv */
`default_nettype none

module zelda (
	input  logic        clock_50,
	input  logic        rst,
	input  logic        btn_up,
	input  logic        btn_down,
	input  logic        btn_left,
	input  logic        btn_right,
	input  logic        btn_attack,
	// Host map port, AXI4-Lite
	input  logic [11:0] s_awaddr,
	input  logic        s_awvalid,
	output logic        s_awready,
	input  logic [31:0] s_wdata,
	input  logic        s_wvalid,
	output logic        s_wready,
	output logic [1:0]  s_bresp,
	output logic        s_bvalid,
	input  logic        s_bready,
	input  logic [11:0] s_araddr,
	input  logic        s_arvalid,
	output logic        s_arready,
	output logic [31:0] s_rdata,
	output logic [1:0]  s_rresp,
	output logic        s_rvalid,
	input  logic        s_rready,
	// Plot stream to the display side
	output logic [7:0]  x,
	output logic [6:0]  y,
	output logic [2:0]  colour,
	output logic        plot,
	output logic        ready
);
	import zelda_pkg::*;

	action_t action;
	dir_t    dir;
	logic    start;
	logic    done;
	logic    redraw_req;

	tile_port_if tile_bus ();

	map_store u_map_store (
		.clock      (clock_50),
		.rst        (rst),
		.s_awaddr   (s_awaddr),
		.s_awvalid  (s_awvalid),
		.s_awready  (s_awready),
		.s_wdata    (s_wdata),
		.s_wvalid   (s_wvalid),
		.s_wready   (s_wready),
		.s_bresp    (s_bresp),
		.s_bvalid   (s_bvalid),
		.s_bready   (s_bready),
		.s_araddr   (s_araddr),
		.s_arvalid  (s_arvalid),
		.s_arready  (s_arready),
		.s_rdata    (s_rdata),
		.s_rresp    (s_rresp),
		.s_rvalid   (s_rvalid),
		.s_rready   (s_rready),
		.tile       (tile_bus.memory),
		.redraw_req (redraw_req)
	);

	control u_control (
		.clock      (clock_50),
		.rst        (rst),
		.btn_up     (btn_up),
		.btn_down   (btn_down),
		.btn_left   (btn_left),
		.btn_right  (btn_right),
		.btn_attack (btn_attack),
		.redraw_req (redraw_req),
		.action     (action),
		.dir        (dir),
		.start      (start),
		.done       (done),
		.ready      (ready)
	);

	datapath u_datapath (
		.clock  (clock_50),
		.rst    (rst),
		.action (action),
		.dir    (dir),
		.start  (start),
		.done   (done),
		.tile   (tile_bus.requester),
		.x      (x),
		.y      (y),
		.colour (colour),
		.plot   (plot)
	);

endmodule

`default_nettype wire

/* bench/zelda_asserts.sv */
`default_nettype none

module zelda_asserts (
	input logic       clock_50,
	input logic       rst,
	input logic       plot,
	input logic       ready,
	input logic [7:0] x,
	input logic [6:0] y,
	input logic       s_bvalid,
	input logic       s_bready,
	input logic       s_rvalid,
	input logic       s_rready
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;   // Summed into the final report

	// No pixels while idle
	a_plot_idle: assert property (@(posedge clock_50) disable iff (rst) !(plot && ready))
		else begin
			$error("plot high while ready is high");
			fail_count++;
		end

	// Write response held until taken
	a_bvalid_hold: assert property (@(posedge clock_50) disable iff (rst)
		s_bvalid && !s_bready |=> s_bvalid)
		else begin
			$error("bvalid dropped before bready");
			fail_count++;
		end

	a_rvalid_hold: assert property (@(posedge clock_50) disable iff (rst)
		s_rvalid && !s_rready |=> s_rvalid)
		else begin
			$error("rvalid dropped before rready");
			fail_count++;
		end

	// Pixel on the 160x120 screen
	a_on_screen: assert property (@(posedge clock_50) disable iff (rst)
		plot |-> (x < 8'd160 && y < 7'd120))
		else begin
			$error("plot outside the screen");
			fail_count++;
		end

endmodule

bind zelda zelda_asserts u_asserts (
	.clock_50 (clock_50),
	.rst      (rst),
	.plot     (plot),
	.ready    (ready),
	.x        (x),
	.y        (y),
	.s_bvalid (s_bvalid),
	.s_bready (s_bready),
	.s_rvalid (s_rvalid),
	.s_rready (s_rready)
);

`default_nettype wire

/* bench/zelda_tb.sv */
`default_nettype none
`include "zelda_params.svh"

module zelda_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import zelda_pkg::*;

	localparam int SCR_W        = `MAP_W * `TILE_PX;
	localparam int SCR_H        = `MAP_H * `TILE_PX;
	localparam int TILE_PLOTS   = `TILE_PX * `TILE_PX;
	localparam int REDRAW_PLOTS = (`MAP_WORDS + 1) * TILE_PLOTS;   // All tiles plus the player
	localparam int BUSH_ADDR    = `START_ROW * `MAP_W + `START_COL + 1;
	localparam logic [4:0] ATTACK_BTN = 5'b00001;

	logic        clock_50 = 1'b0;
	logic        rst;
	logic        btn_up, btn_down, btn_left, btn_right, btn_attack;
	logic [11:0] s_awaddr, s_araddr;
	logic [31:0] s_wdata, s_rdata;
	logic        s_awvalid, s_awready, s_wvalid, s_wready;
	logic [1:0]  s_bresp, s_rresp;
	logic        s_bvalid, s_bready, s_arvalid, s_arready, s_rvalid, s_rready;
	logic [7:0]  x;
	logic [6:0]  y;
	logic [2:0]  colour;
	logic        plot, ready;

	logic [1:0]  shadow [`MAP_WORDS];    // Tile codes as the host wrote them
	logic [2:0]  frame [SCR_W * SCR_H];  // Last colour plotted per pixel
	int          plot_count;
	int          pcol, prow;             // Player model
	dir_t        facing;
	logic [31:0] lcg_state;
	int          errors, test_base, pass_count, fail_count;

	zelda u_zelda (.*);

	always #5 clock_50 = ~clock_50;

	// Plot monitor, stable mid-cycle
	always @(negedge clock_50) begin
		if (plot) begin
			if (x < 8'(SCR_W) && y < 7'(SCR_H))
				frame[int'(y) * SCR_W + int'(x)] = colour;
			plot_count++;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Expected pixel from shadow map and player
	function automatic logic [2:0] expected_colour(input int px, input int py);
		int c, r;
		c = px / `TILE_PX;
		r = py / `TILE_PX;
		if (c == pcol && r == prow)
			return `COL_PLAYER;
		case (shadow[r * `MAP_W + c])
			2'd0:    return `COL_FLOOR;
			2'd2:    return `COL_BUSH;
			default: return `COL_WALL;   // Code 3 counts as wall
		endcase
	endfunction

	// Neighbour of the player, false when off the grid
	function automatic bit neighbour(input dir_t d, output int c, output int r);
		c = pcol;
		r = prow;
		case (d)
			UP:      r = prow - 1;
			DOWN:    r = prow + 1;
			LEFT:    c = pcol - 1;
			default: c = pcol + 1;
		endcase
		return c >= 0 && c < `MAP_W && r >= 0 && r < `MAP_H;
	endfunction

	// Turn always, step only onto floor
	function automatic int model_move(input dir_t d);
		int c, r;
		facing = d;
		if (neighbour(d, c, r) && shadow[r * `MAP_W + c] == 2'd0) begin
			pcol = c;
			prow = r;
			return 2 * TILE_PLOTS;   // Old tile as floor, then player
		end
		return 0;
	endfunction

	function automatic int model_attack();
		int c, r;
		if (neighbour(facing, c, r) && shadow[r * `MAP_W + c] == 2'd2) begin
			shadow[r * `MAP_W + c] = 2'd0;
			return TILE_PLOTS;
		end
		return 0;
	endfunction

	function automatic logic [4:0] dir_mask(input dir_t d);
		case (d)
			UP:      return 5'b10000;
			DOWN:    return 5'b01000;
			LEFT:    return 5'b00100;
			default: return 5'b00010;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Test failed");
		$finish;
	endtask

	task automatic wait_ready(input int limit, input string what);
		int n;
		n = 0;
		while (!ready && n < limit) begin
			@(negedge clock_50);
			n++;
		end
		if (!ready)
			stop_on_timeout({what, " to finish"});
	endtask

	task automatic wait_busy(input int limit, input string what);
		int n;
		n = 0;
		while (ready && n < limit) begin
			@(negedge clock_50);
			n++;
		end
		if (ready)
			stop_on_timeout({what, " to start"});
	endtask

	task automatic write_word(input logic [11:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int n;
		s_awaddr  = addr;
		s_wdata   = data;
		s_awvalid = 1'b1;
		s_wvalid  = 1'b1;
		s_bready  = 1'b0;   // Response held back for a cycle
		n = 0;
		while (!s_awready && n < 20) begin
			@(negedge clock_50);
			n++;
		end
		if (!s_awready)
			stop_on_timeout("AXI write accept");
		else begin
			check_value("s_wready", s_wready, 1'b1);   // Address and data taken together
			@(negedge clock_50);
			s_awvalid = 1'b0;
			s_wvalid  = 1'b0;
			check_value("s_awready", s_awready, 1'b0);   // One-cycle accept
			check_value("s_bvalid", s_bvalid, 1'b1);
			resp = s_bresp;
			@(negedge clock_50);
			check_value("s_bvalid held", s_bvalid, 1'b1);
			s_bready = 1'b1;
			@(negedge clock_50);
			s_bready = 1'b0;
			check_value("s_bvalid after bready", s_bvalid, 1'b0);
		end
	endtask

	task automatic read_word(input logic [11:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		s_araddr  = addr;
		s_arvalid = 1'b1;
		s_rready  = 1'b0;   // Data held back for a cycle
		n = 0;
		while (!s_arready && n < 20) begin
			@(negedge clock_50);
			n++;
		end
		if (!s_arready)
			stop_on_timeout("AXI read accept");
		else begin
			@(negedge clock_50);   // Address taken on this edge
			s_arvalid = 1'b0;
			check_value("s_rvalid", s_rvalid, 1'b1);
			data = s_rdata;
			resp = s_rresp;
			@(negedge clock_50);
			check_value("s_rvalid held", s_rvalid, 1'b1);
			s_rready = 1'b1;
			@(negedge clock_50);
			s_rready = 1'b0;
			check_value("s_rvalid after rready", s_rvalid, 1'b0);
		end
	endtask

	task automatic press_button(input logic [4:0] mask);
		{btn_up, btn_down, btn_left, btn_right, btn_attack} = mask;
		@(negedge clock_50);
		{btn_up, btn_down, btn_left, btn_right, btn_attack} = 5'b00000;
	endtask

	task automatic clear_frame();
		int i;
		for (i = 0; i < SCR_W * SCR_H; i++)
			frame[i] = 3'bxxx;   // Unplotted pixels then show up
	endtask

	// Whole frame against the model, first bad pixel reported
	task automatic check_frame();
		int i, bad, first;
		bad   = 0;
		first = 0;
		for (i = 0; i < SCR_W * SCR_H; i++) begin
			if (frame[i] !== expected_colour(i % SCR_W, i / SCR_W)) begin
				if (bad == 0)
					first = i;
				bad++;
			end
		end
		if (bad != 0) begin
			check_value($sformatf("colour at (%0d,%0d)", first % SCR_W, first / SCR_W),
				frame[first], expected_colour(first % SCR_W, first / SCR_W));
			$display("Frame differs from the model in %0d pixels", bad);
		end
	endtask

	task automatic press_and_check(input logic [4:0] mask, input int exp_plots, input string what);
		plot_count = 0;
		press_button(mask);
		wait_ready(2000, what);
		check_value({what, " plot count"}, plot_count, exp_plots);
		check_frame();
	endtask

	task automatic do_redraw(input string what);
		logic [1:0] resp;
		clear_frame();
		plot_count = 0;
		write_word(`REDRAW_ADDR, 32'd0, resp);
		check_value("s_bresp", resp, 2'b00);
		wait_busy(10, what);
		wait_ready(30000, what);
		pcol = `START_COL;
		prow = `START_ROW;
		check_value({what, " plot count"}, plot_count, REDRAW_PLOTS);
		check_frame();
	endtask

	task automatic build_map();
		int c, r, v;
		for (r = 0; r < `MAP_H; r++) begin
			for (c = 0; c < `MAP_W; c++) begin
				v = int'((lcg_next() >> 16) % 8);
				if (r == 0 || c == 0 || r == `MAP_H - 1 || c == `MAP_W - 1)
					shadow[r * `MAP_W + c] = 2'd1;   // Border wall
				else if (v < 5)
					shadow[r * `MAP_W + c] = 2'd0;
				else if (v == 5)
					shadow[r * `MAP_W + c] = 2'd1;
				else
					shadow[r * `MAP_W + c] = 2'd2;
			end
		end
		shadow[`START_ROW * `MAP_W + `START_COL] = 2'd0;
		shadow[BUSH_ADDR] = 2'd2;                                // Bush right of spawn
		shadow[(`START_ROW + 1) * `MAP_W + `START_COL] = 2'd0;   // Floor below spawn
	endtask

	task automatic end_test(input string name);
		if (errors == test_base) begin
			pass_count++;
			$display("PASS  %s", name);
		end else begin
			fail_count++;
			$display("FAIL  %s, %0d errors", name, errors - test_base);
		end
		test_base = errors;
	endtask

	initial begin
		logic [1:0]  resp;
		logic [31:0] data;
		int          n, exp;
		dir_t        d;
		rst = 1'b1;
		{btn_up, btn_down, btn_left, btn_right, btn_attack} = 5'b00000;
		s_awaddr  = '0;
		s_awvalid = 1'b0;
		s_wdata   = '0;
		s_wvalid  = 1'b0;
		s_bready  = 1'b0;
		s_araddr  = '0;
		s_arvalid = 1'b0;
		s_rready  = 1'b0;
		lcg_state = 32'd17479;
		errors     = 0;
		test_base  = 0;
		pass_count = 0;
		fail_count = 0;
		plot_count = 0;
		pcol   = `START_COL;
		prow   = `START_ROW;
		facing = DOWN;
		build_map();
		repeat (4) @(negedge clock_50);
		rst = 1'b0;

		// Reset state, map load, readback, bad address
		check_value("ready", ready, 1'b1);
		check_value("plot", plot, 1'b0);
		check_value("s_bvalid", s_bvalid, 1'b0);
		check_value("s_rvalid", s_rvalid, 1'b0);
		for (n = 0; n < `MAP_WORDS; n++) begin
			write_word(12'(n * 4), {30'd0, shadow[n]}, resp);
			check_value("s_bresp", resp, 2'b00);
		end
		for (n = 0; n < `MAP_WORDS; n++) begin
			read_word(12'(n * 4), data, resp);
			check_value($sformatf("s_rdata[%0d]", n), data, {30'd0, shadow[n]});
			check_value("s_rresp", resp, 2'b00);
		end
		write_word(12'(`MAP_WORDS * 4), 32'd1, resp);   // First word past the map
		check_value("s_bresp unmapped", resp, 2'b10);
		read_word(12'(`MAP_WORDS * 4), data, resp);
		check_value("s_rresp unmapped", resp, 2'b10);
		end_test("map load and readback");

		do_redraw("redraw");
		end_test("full redraw");

		for (n = 0; n < 40; n++) begin
			d   = dir_t'(2'(lcg_next() >> 16));
			exp = model_move(d);
			press_and_check(dir_mask(d), exp, $sformatf("move %0d", n));
		end
		end_test("moves");

		// Spawn faces the forced bush on its right
		do_redraw("redraw before attack");
		press_and_check(dir_mask(RIGHT), model_move(RIGHT), "face bush");
		exp = model_attack();
		press_and_check(ATTACK_BTN, exp, "attack bush");
		read_word(12'(BUSH_ADDR * 4), data, resp);
		check_value("s_rdata cleared bush", data, 32'd0);
		press_and_check(ATTACK_BTN, model_attack(), "attack floor");
		press_and_check(dir_mask(UP), model_move(UP), "face wall");
		press_and_check(ATTACK_BTN, model_attack(), "attack wall");
		end_test("attack");

		// Edge during a move is lost
		exp = model_move(DOWN);
		plot_count = 0;
		press_button(dir_mask(DOWN));
		repeat (5) @(negedge clock_50);
		press_button(dir_mask(UP));
		wait_ready(2000, "move with busy press");
		repeat (10) begin
			@(negedge clock_50);
			check_value("ready after busy press", ready, 1'b1);
		end
		check_value("busy move plot count", plot_count, exp);
		check_frame();
		// Redraw written mid-move, served right after
		exp = model_move(UP) + REDRAW_PLOTS;
		clear_frame();
		plot_count = 0;
		press_button(dir_mask(UP));
		repeat (3) @(negedge clock_50);
		write_word(`REDRAW_ADDR, 32'd0, resp);
		check_value("s_bresp", resp, 2'b00);
		wait_ready(2000, "move before held redraw");
		wait_busy(10, "held redraw");
		wait_ready(30000, "held redraw");
		pcol = `START_COL;
		prow = `START_ROW;
		check_value("move and redraw plot count", plot_count, exp);
		check_frame();
		end_test("busy behavior");

		n = u_zelda.u_asserts.fail_count;
		$display("Tests passed %0d, failed %0d, assertion failures %0d", pass_count, fail_count, n);
		if (fail_count == 0 && n == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
src/zelda_pkg.sv
src/tile_port_if.sv
src/map_store.sv
src/control.sv
src/datapath.sv
src/zelda.sv
bench/zelda_asserts.sv
bench/zelda_tb.sv

/* Makefile */
# Verilator build and run of zelda_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, scan sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module zelda_tb -f build.f -o zelda_sim
	./obj_dir/zelda_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test completed successfully" sim.log || (echo "No pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
